// File: files.f
+incdir+hdl
hdl/ecc_pm_pkg.sv
hdl/ecc_pm_sequencer.sv
hdl/ecc_pm_ctrl.sv
hdl/ecc_pm_apb_regs.sv
hdl/ecc_pm_top.sv
test/tb_ecc_pm.sv

// File: hdl/ecc_pm_apb_regs.sv
/*
 * APB register block for the point-multiplication controller
 * Command launch, scalar digit shift register and status readback
 */
`timescale 1ns/100ps
`include "ecc_pm_macros.svh"

module ecc_pm_apb_regs (
    input  logic             clk,
    input  logic             reset_n,
    input  logic [3:0]       paddr_i,
    input  logic             psel_i,
    input  logic             penable_i,
    input  logic             pwrite_i,
    input  logic [31:0]      pwdata_i,
    output logic [31:0]      prdata_o,
    output logic             pready_o,
    output logic             pslverr_o,
    input  logic             busy_i,
    input  logic             req_digit_i,
    output ecc_pm_pkg::cmd_e cmd_o,
    output logic             digit_o
);

    ecc_pm_pkg::scalar_t scalar;
    ecc_pm_pkg::cmd_e    wr_cmd;
    logic                wr_access;
    logic                cmd_write;
    logic                cmd_valid;

    assign wr_access = psel_i & penable_i & pwrite_i;
    assign cmd_write = wr_access && paddr_i == `PM_REG_CMD;
    assign wr_cmd    = ecc_pm_pkg::cmd_e'(pwdata_i[2:0]);
    assign cmd_valid = wr_cmd inside {ecc_pm_pkg::CMD_KEYGEN, ecc_pm_pkg::CMD_SIGN,
                                      ecc_pm_pkg::CMD_VER0, ecc_pm_pkg::CMD_VER1,
                                      ecc_pm_pkg::CMD_VER2};

    assign pready_o  = 1'b1;  // Zero wait states
    // Pending launch counts as busy
    assign pslverr_o = cmd_write & (busy_i | (cmd_o != ecc_pm_pkg::CMD_NONE) | ~cmd_valid);

    // --------------------------------------------------
    // Command launch pulse
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            cmd_o <= ecc_pm_pkg::CMD_NONE;
        end else if (cmd_write && !pslverr_o) begin
            cmd_o <= wr_cmd;
        end else begin
            cmd_o <= ecc_pm_pkg::CMD_NONE;
        end
    end

    // --------------------------------------------------
    // Scalar shift register, MSB is the current digit
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (wr_access && paddr_i == `PM_REG_SCALAR) begin
            scalar <= pwdata_i[`PM_LADDER_BITS-1:0];
        end else if (req_digit_i) begin
            scalar <= {scalar[`PM_LADDER_BITS-2:0], 1'b0};
        end
    end

    assign digit_o = scalar[`PM_LADDER_BITS-1];

    always_comb begin
        prdata_o = '0;
        if (psel_i && !pwrite_i) begin
            case (paddr_i)
                `PM_REG_SCALAR: prdata_o[`PM_LADDER_BITS-1:0] = scalar;
                `PM_REG_STATUS: begin
                    prdata_o[0]                    = busy_i;
                    prdata_o[8 +: `PM_LADDER_BITS] = scalar;  // Remaining digits
                end
                default: prdata_o = '0;
            endcase
        end
    end

endmodule

// File: hdl/ecc_pm_ctrl.sv
/*
 * Point-multiplication microcode controller
 * Walks the program ROM per command, stalls on arithmetic micro-ops,
 * runs the ladder and issues remapped instruction words
 */
`timescale 1ns/100ps
`include "ecc_pm_macros.svh"

module ecc_pm_ctrl (
    input  logic               clk,
    input  logic               reset_n,
    input  ecc_pm_pkg::cmd_e   cmd_i,
    input  logic               digit_i,
    output logic               req_digit_o,
    output logic               busy_o,
    output ecc_pm_pkg::instr_t instr_o
);

    ecc_pm_pkg::prog_addr_t  prog_cntr;
    ecc_pm_pkg::prog_addr_t  line_addr;     // Address of prog_line
    ecc_pm_pkg::instr_t      prog_line;
    ecc_pm_pkg::instr_t      pipe1;
    ecc_pm_pkg::instr_t      pipe2;
    ecc_pm_pkg::ladder_cnt_t ladder_cnt;
    ecc_pm_pkg::cmd_e        cmd_reg;
    logic [7:0]              stall_cntr;
    logic                    stalled;
    logic                    stall_flag;
    logic                    mul_flag;
    logic                    advance;
    logic                    ladder1, ladder2;  // Line belongs to PA or PD
    logic                    step_end1, step_end2;
    logic                    swap_a, swap_b;

    ecc_pm_sequencer u_sequencer (
        .clk    (clk),
        .addr_i (prog_cntr),
        .line_o (prog_line)
    );

    // --------------------------------------------------
    // Micro-op decode and program counter
    // --------------------------------------------------
    always_comb begin
        case (prog_line[23:16])
            ecc_pm_pkg::UOP_ADD_p, ecc_pm_pkg::UOP_SUB_p,
            ecc_pm_pkg::UOP_ADD_q, ecc_pm_pkg::UOP_SUB_q: begin
                stall_flag = 1'b1;
                mul_flag   = 1'b0;
            end
            ecc_pm_pkg::UOP_MUL_p, ecc_pm_pkg::UOP_MUL_q: begin
                stall_flag = 1'b1;
                mul_flag   = 1'b1;
            end
            default: begin
                stall_flag = 1'b0;
                mul_flag   = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            prog_cntr  <= ecc_pm_pkg::NOP;
            ladder_cnt <= '0;
            stall_cntr <= '0;
            stalled    <= 1'b0;
            cmd_reg    <= ecc_pm_pkg::CMD_NONE;
        end else if (stalled && stall_cntr != 8'd0) begin
            stall_cntr <= stall_cntr - 8'd1;
        end else if (!stalled && stall_flag) begin
            stalled    <= 1'b1;
            stall_cntr <= mul_flag ? 8'(`PM_MUL_DELAY) : 8'(`PM_ADD_DELAY);
        end else begin
            stalled <= 1'b0;
            case (prog_cntr)
                ecc_pm_pkg::NOP: begin  // Idle, wait for a command
                    cmd_reg <= cmd_i;
                    case (cmd_i)
                        ecc_pm_pkg::CMD_KEYGEN, ecc_pm_pkg::CMD_SIGN,
                        ecc_pm_pkg::CMD_VER1: begin
                            ladder_cnt <= ecc_pm_pkg::ladder_cnt_t'(`PM_LADDER_BITS);
                            prog_cntr  <= ecc_pm_pkg::INIT_G_S;
                        end
                        ecc_pm_pkg::CMD_VER0: prog_cntr <= ecc_pm_pkg::VER0_P0_S;
                        ecc_pm_pkg::CMD_VER2: prog_cntr <= ecc_pm_pkg::VER1_ST_S;
                        default:              prog_cntr <= ecc_pm_pkg::NOP;
                    endcase
                end
                ecc_pm_pkg::VER1_ST_E: begin  // Second ladder starts from PK
                    ladder_cnt <= ecc_pm_pkg::ladder_cnt_t'(`PM_LADDER_BITS);
                    prog_cntr  <= ecc_pm_pkg::INIT_PK_S;
                end
                ecc_pm_pkg::INIT_G_E:  prog_cntr <= ecc_pm_pkg::INIT_S;
                ecc_pm_pkg::INIT_PK_E: prog_cntr <= ecc_pm_pkg::INIT_S;
                ecc_pm_pkg::INIT_E: begin  // First ladder step
                    ladder_cnt <= ladder_cnt - 4'd1;
                    prog_cntr  <= ecc_pm_pkg::PA_S;
                end
                ecc_pm_pkg::PA_E: prog_cntr <= ecc_pm_pkg::PD_S;
                ecc_pm_pkg::PD_E: begin
                    if (ladder_cnt == 4'd0) begin
                        case (cmd_reg)
                            ecc_pm_pkg::CMD_VER1: prog_cntr <= ecc_pm_pkg::NOP;
                            ecc_pm_pkg::CMD_VER2: prog_cntr <= ecc_pm_pkg::VER2_PA_S;
                            default:              prog_cntr <= ecc_pm_pkg::INV_S;
                        endcase
                    end else begin
                        ladder_cnt <= ladder_cnt - 4'd1;
                        prog_cntr  <= ecc_pm_pkg::PA_S;
                    end
                end
                ecc_pm_pkg::INV_E: prog_cntr <= ecc_pm_pkg::CONV_S;
                ecc_pm_pkg::CONV_E: begin
                    if (cmd_reg == ecc_pm_pkg::CMD_SIGN)
                        prog_cntr <= ecc_pm_pkg::SIGN0_S;
                    else
                        prog_cntr <= ecc_pm_pkg::NOP;
                end
                ecc_pm_pkg::SIGN0_E: prog_cntr <= ecc_pm_pkg::INVq_S;
                ecc_pm_pkg::INVq_E: begin
                    case (cmd_reg)
                        ecc_pm_pkg::CMD_SIGN: prog_cntr <= ecc_pm_pkg::SIGN1_S;
                        ecc_pm_pkg::CMD_VER0: prog_cntr <= ecc_pm_pkg::VER0_P1_S;
                        default:              prog_cntr <= ecc_pm_pkg::NOP;
                    endcase
                end
                ecc_pm_pkg::SIGN1_E:   prog_cntr <= ecc_pm_pkg::NOP;
                ecc_pm_pkg::VER0_P0_E: prog_cntr <= ecc_pm_pkg::INVq_S;
                ecc_pm_pkg::VER0_P1_E: prog_cntr <= ecc_pm_pkg::NOP;
                ecc_pm_pkg::VER2_PA_E: prog_cntr <= ecc_pm_pkg::INV_S;
                default:               prog_cntr <= prog_cntr + 6'd1;
            endcase
        end
    end

    // --------------------------------------------------
    // Instruction pipeline, frozen while stalled
    // --------------------------------------------------
    assign advance = ~stalled;

    always_ff @(posedge clk) begin
        line_addr <= prog_cntr;  // Tracks the ROM address register
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            pipe1     <= '0;
            pipe2     <= '0;
            ladder1   <= 1'b0;
            ladder2   <= 1'b0;
            step_end1 <= 1'b0;
            step_end2 <= 1'b0;
        end else if (advance) begin
            pipe1     <= prog_line;
            ladder1   <= line_addr inside {[ecc_pm_pkg::PA_S : ecc_pm_pkg::PD_E]};
            step_end1 <= line_addr == ecc_pm_pkg::PD_E;
            pipe2     <= pipe1;
            ladder2   <= ladder1;
            step_end2 <= step_end1;
        end
    end

    // Bank swap on ladder addresses 00001xxx
    assign swap_a = ladder2 && pipe2[15:11] == 5'b00001 && digit_i;
    assign swap_b = ladder2 && pipe2[7:3] == 5'b00001 && digit_i;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            instr_o <= '0;
        end else if (!advance) begin
            instr_o <= '0;  // Each line is issued once
        end else begin
            instr_o[23:22] <= 2'b00;
            instr_o[21]    <= pipe2[21];  // Mod q select
            case (pipe2[20:18])
                3'b001:  instr_o[20:18] <= 3'b010;  // RED
                3'b011:  instr_o[20:18] <= 3'b001;  // SUB
                3'b100:  instr_o[20:18] <= 3'b100;  // MUL
                default: instr_o[20:18] <= 3'b000;  // ADD and NOP
            endcase
            instr_o[17:16] <= pipe2[17:16];  // Write enables A, B
            instr_o[15:8]  <= {pipe2[15:11], pipe2[10] ^ swap_a, pipe2[9:8]};
            instr_o[7:0]   <= {pipe2[7:3], pipe2[2] ^ swap_b, pipe2[1:0]};
        end
    end

    // Next digit once the step's last word leaves
    assign req_digit_o = advance & step_end2;

    assign busy_o = (prog_cntr != ecc_pm_pkg::NOP) | stalled | (prog_line != '0) |
                    (pipe1 != '0) | (pipe2 != '0);

endmodule

// File: hdl/ecc_pm_macros.svh
/*
 * Point-multiplication control build constants
 * Widths, ladder length, arithmetic stall delays and APB register map
 */
`ifndef ECC_PM_MACROS_SVH
`define ECC_PM_MACROS_SVH

// --------------------------------------------------
// Program and instruction widths
// --------------------------------------------------
`define PM_PROG_ADDR_W  6      // 64-line program ROM
`define PM_INSTR_W      24     // Program line and issued instruction

// Ladder steps, also the scalar register width
`define PM_LADDER_BITS  8

// --------------------------------------------------
// Extra stall cycles per arithmetic micro-op
// --------------------------------------------------
`define PM_MUL_DELAY    38
`define PM_ADD_DELAY    0

// APB byte offsets
`define PM_REG_CMD      4'h0
`define PM_REG_SCALAR   4'h4
`define PM_REG_STATUS   4'h8

`endif

// File: hdl/ecc_pm_pkg.sv
/*
 * Shared types for the point-multiplication controller
 * Command codes, micro-op codes and microprogram routine addresses
 */
`include "ecc_pm_macros.svh"

package ecc_pm_pkg;

    typedef logic [`PM_PROG_ADDR_W-1:0] prog_addr_t;
    typedef logic [`PM_INSTR_W-1:0]     instr_t;
    typedef logic [`PM_LADDER_BITS-1:0] scalar_t;
    typedef logic [3:0]                 ladder_cnt_t;

    typedef enum logic [2:0] {
        CMD_NONE   = 3'd0,
        CMD_KEYGEN = 3'd1,
        CMD_SIGN   = 3'd2,
        CMD_VER0   = 3'd3,
        CMD_VER1   = 3'd4,
        CMD_VER2   = 3'd5
    } cmd_e;

    // Micro-op byte is {2'b00, mod_q, opcode[2:0], write_a, write_b}
    localparam logic [7:0] UOP_ADD_p = 8'h0A;
    localparam logic [7:0] UOP_SUB_p = 8'h0E;
    localparam logic [7:0] UOP_MUL_p = 8'h11;
    localparam logic [7:0] UOP_ADD_q = 8'h2A;
    localparam logic [7:0] UOP_SUB_q = 8'h2E;
    localparam logic [7:0] UOP_MUL_q = 8'h31;

    // --------------------------------------------------
    // Routine start and end addresses
    // --------------------------------------------------
    localparam prog_addr_t NOP         = 6'd0;
    localparam prog_addr_t INIT_G_S    = 6'd1;
    localparam prog_addr_t INIT_G_E    = 6'd2;
    localparam prog_addr_t INIT_PK_S   = 6'd3;
    localparam prog_addr_t INIT_PK_E   = 6'd4;
    localparam prog_addr_t INIT_S      = 6'd5;
    localparam prog_addr_t INIT_E      = 6'd6;
    localparam prog_addr_t PA_S        = 6'd7;
    localparam prog_addr_t PA_E        = 6'd9;
    localparam prog_addr_t PD_S        = 6'd10;
    localparam prog_addr_t PD_E        = 6'd12;
    localparam prog_addr_t INV_S       = 6'd13;
    localparam prog_addr_t INV_E       = 6'd14;
    localparam prog_addr_t CONV_S      = 6'd15;
    localparam prog_addr_t CONV_E      = 6'd16;
    localparam prog_addr_t SIGN0_S     = 6'd17;
    localparam prog_addr_t SIGN0_E     = 6'd18;
    localparam prog_addr_t INVq_S      = 6'd19;
    localparam prog_addr_t INVq_E      = 6'd20;
    localparam prog_addr_t SIGN1_S     = 6'd21;
    localparam prog_addr_t SIGN1_E     = 6'd22;
    localparam prog_addr_t VER0_P0_S   = 6'd23;
    localparam prog_addr_t VER0_P0_E   = 6'd24;
    localparam prog_addr_t VER0_P1_S   = 6'd25;
    localparam prog_addr_t VER0_P1_E   = 6'd26;
    localparam prog_addr_t VER1_ST_S   = 6'd27;
    localparam prog_addr_t VER1_ST_E   = 6'd28;
    localparam prog_addr_t VER2_PA_S   = 6'd29;
    localparam prog_addr_t VER2_PA_E   = 6'd31;

endpackage

// File: hdl/ecc_pm_sequencer.sv
/*
 * Microprogram ROM
 * Registered address, one program line per cycle
 */
`timescale 1ns/100ps

module ecc_pm_sequencer (
    input  logic                   clk,
    input  ecc_pm_pkg::prog_addr_t addr_i,
    output ecc_pm_pkg::instr_t     line_o
);

    ecc_pm_pkg::prog_addr_t addr_q;

    // Line layout is {micro-op, address A, address B}
    function automatic ecc_pm_pkg::instr_t op(input logic [7:0] uop,
                                              input logic [7:0] addr_a,
                                              input logic [7:0] addr_b);
        return {uop, addr_a, addr_b};
    endfunction

    always_ff @(posedge clk) begin
        addr_q <= addr_i;
    end

    always_comb begin
        case (addr_q)
            ecc_pm_pkg::INIT_G_S        : line_o = op(ecc_pm_pkg::UOP_MUL_p, 8'h10, 8'h20);
            ecc_pm_pkg::INIT_G_E        : line_o = op(ecc_pm_pkg::UOP_ADD_p, 8'h11, 8'h21);
            ecc_pm_pkg::INIT_PK_S       : line_o = op(ecc_pm_pkg::UOP_MUL_p, 8'h12, 8'h22);
            ecc_pm_pkg::INIT_PK_E       : line_o = op(ecc_pm_pkg::UOP_ADD_p, 8'h13, 8'h23);
            ecc_pm_pkg::INIT_S          : line_o = op(ecc_pm_pkg::UOP_SUB_p, 8'h14, 8'h24);
            ecc_pm_pkg::INIT_E          : line_o = op(ecc_pm_pkg::UOP_MUL_p, 8'h15, 8'h25);
            // Ladder lines, banks 0x08 and 0x0C swap with the digit
            ecc_pm_pkg::PA_S            : line_o = op(ecc_pm_pkg::UOP_MUL_p, 8'h08, 8'h0D);
            ecc_pm_pkg::PA_S + 6'd1     : line_o = op(ecc_pm_pkg::UOP_ADD_p, 8'h09, 8'h26);
            ecc_pm_pkg::PA_E            : line_o = op(ecc_pm_pkg::UOP_SUB_p, 8'h16, 8'h0C);
            ecc_pm_pkg::PD_S            : line_o = op(ecc_pm_pkg::UOP_MUL_p, 8'h0A, 8'h27);
            ecc_pm_pkg::PD_S + 6'd1     : line_o = op(ecc_pm_pkg::UOP_ADD_p, 8'h0E, 8'h0B);
            ecc_pm_pkg::PD_E            : line_o = op(ecc_pm_pkg::UOP_MUL_p, 8'h17, 8'h0F);
            ecc_pm_pkg::INV_S           : line_o = op(ecc_pm_pkg::UOP_MUL_p, 8'h18, 8'h28);
            ecc_pm_pkg::INV_E           : line_o = op(ecc_pm_pkg::UOP_SUB_p, 8'h19, 8'h29);
            ecc_pm_pkg::CONV_S          : line_o = op(ecc_pm_pkg::UOP_MUL_p, 8'h1A, 8'h2A);
            ecc_pm_pkg::CONV_E          : line_o = op(ecc_pm_pkg::UOP_ADD_p, 8'h1B, 8'h2B);
            // Scalar-field routines run mod q
            ecc_pm_pkg::SIGN0_S         : line_o = op(ecc_pm_pkg::UOP_MUL_q, 8'h30, 8'h38);
            ecc_pm_pkg::SIGN0_E         : line_o = op(ecc_pm_pkg::UOP_ADD_q, 8'h31, 8'h39);
            ecc_pm_pkg::INVq_S          : line_o = op(ecc_pm_pkg::UOP_MUL_q, 8'h32, 8'h3A);
            ecc_pm_pkg::INVq_E          : line_o = op(ecc_pm_pkg::UOP_SUB_q, 8'h33, 8'h3B);
            ecc_pm_pkg::SIGN1_S         : line_o = op(ecc_pm_pkg::UOP_MUL_q, 8'h34, 8'h3C);
            ecc_pm_pkg::SIGN1_E         : line_o = op(ecc_pm_pkg::UOP_ADD_q, 8'h35, 8'h3D);
            ecc_pm_pkg::VER0_P0_S       : line_o = op(ecc_pm_pkg::UOP_MUL_q, 8'h36, 8'h3E);
            ecc_pm_pkg::VER0_P0_E       : line_o = op(ecc_pm_pkg::UOP_SUB_q, 8'h37, 8'h3F);
            ecc_pm_pkg::VER0_P1_S       : line_o = op(ecc_pm_pkg::UOP_MUL_q, 8'h40, 8'h48);
            ecc_pm_pkg::VER0_P1_E       : line_o = op(ecc_pm_pkg::UOP_ADD_q, 8'h41, 8'h49);
            ecc_pm_pkg::VER1_ST_S       : line_o = op(ecc_pm_pkg::UOP_ADD_p, 8'h1C, 8'h2C);
            ecc_pm_pkg::VER1_ST_E       : line_o = op(ecc_pm_pkg::UOP_SUB_p, 8'h1D, 8'h2D);
            ecc_pm_pkg::VER2_PA_S       : line_o = op(ecc_pm_pkg::UOP_MUL_p, 8'h1E, 8'h2E);
            ecc_pm_pkg::VER2_PA_S + 6'd1: line_o = op(ecc_pm_pkg::UOP_ADD_p, 8'h1F, 8'h2F);
            ecc_pm_pkg::VER2_PA_E       : line_o = op(ecc_pm_pkg::UOP_SUB_p, 8'h42, 8'h4A);
            default                     : line_o = '0;  // NOP and unused lines
        endcase
    end

endmodule

// File: hdl/ecc_pm_top.sv
/*
 * Point-multiplication control subsystem top level
 * APB registers feeding the microcode controller
 */
`timescale 1ns/100ps

module ecc_pm_top (
    input  logic               clk,
    input  logic               reset_n,
    input  logic [3:0]         paddr_i,
    input  logic               psel_i,
    input  logic               penable_i,
    input  logic               pwrite_i,
    input  logic [31:0]        pwdata_i,
    output logic [31:0]        prdata_o,
    output logic               pready_o,
    output logic               pslverr_o,
    output logic               busy_o,
    output ecc_pm_pkg::instr_t instr_o
);

    ecc_pm_pkg::cmd_e cmd;
    logic             digit;
    logic             req_digit;

    ecc_pm_apb_regs u_apb_regs (
        .clk         (clk),
        .reset_n     (reset_n),
        .paddr_i     (paddr_i),
        .psel_i      (psel_i),
        .penable_i   (penable_i),
        .pwrite_i    (pwrite_i),
        .pwdata_i    (pwdata_i),
        .prdata_o    (prdata_o),
        .pready_o    (pready_o),
        .pslverr_o   (pslverr_o),
        .busy_i      (busy_o),
        .req_digit_i (req_digit),
        .cmd_o       (cmd),
        .digit_o     (digit)
    );

    ecc_pm_ctrl u_ctrl (
        .clk         (clk),
        .reset_n     (reset_n),
        .cmd_i       (cmd),
        .digit_i     (digit),
        .req_digit_o (req_digit),
        .busy_o      (busy_o),
        .instr_o     (instr_o)
    );

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the point-multiplication testbench with Verilator
# The exit status is nonzero when the build or any check fails
cd "$(dirname "$0")" &&
verilator --binary --timing --timescale 1ns/100ps \
    --top-module tb_ecc_pm -f files.f &&
./obj_dir/Vtb_ecc_pm ||
{
    echo "Simulation did not pass"
    exit 1
}

// File: test/ecc_pm_tests.txt
# cmd scalar remaining-digits word-count, then the expected non-zero instr_o words in order
# cmd 1 keygen, 2 sign, 3 verify 0, 4 verify 1, 5 verify 2, all values in hex
1 00 00 38
111020 021121 061424 111525
11080D 020926 06160C 110A27 020E0B 11170F 11080D 020926 06160C 110A27 020E0B 11170F
11080D 020926 06160C 110A27 020E0B 11170F 11080D 020926 06160C 110A27 020E0B 11170F
11080D 020926 06160C 110A27 020E0B 11170F 11080D 020926 06160C 110A27 020E0B 11170F
11080D 020926 06160C 110A27 020E0B 11170F 11080D 020926 06160C 110A27 020E0B 11170F
111828 061929 111A2A 021B2B
2 FF 00 3E
111020 021121 061424 111525
110C09 020D26 061608 110E27 020A0F 11170B 110C09 020D26 061608 110E27 020A0F 11170B
110C09 020D26 061608 110E27 020A0F 11170B 110C09 020D26 061608 110E27 020A0F 11170B
110C09 020D26 061608 110E27 020A0F 11170B 110C09 020D26 061608 110E27 020A0F 11170B
110C09 020D26 061608 110E27 020A0F 11170B 110C09 020D26 061608 110E27 020A0F 11170B
111828 061929 111A2A 021B2B 313038 223139 31323A 26333B 31343C 22353D
3 A5 A5 6
31363E 26373F 31323A 26333B 314048 224149
4 96 00 34
111020 021121 061424 111525
110C09 020D26 061608 110E27 020A0F 11170B 11080D 020926 06160C 110A27 020E0B 11170F
11080D 020926 06160C 110A27 020E0B 11170F 110C09 020D26 061608 110E27 020A0F 11170B
11080D 020926 06160C 110A27 020E0B 11170F 110C09 020D26 061608 110E27 020A0F 11170B
110C09 020D26 061608 110E27 020A0F 11170B 11080D 020926 06160C 110A27 020E0B 11170F
5 3C 00 3D
021C2C 061D2D 111222 021323 061424 111525
11080D 020926 06160C 110A27 020E0B 11170F 11080D 020926 06160C 110A27 020E0B 11170F
110C09 020D26 061608 110E27 020A0F 11170B 110C09 020D26 061608 110E27 020A0F 11170B
110C09 020D26 061608 110E27 020A0F 11170B 110C09 020D26 061608 110E27 020A0F 11170B
11080D 020926 06160C 110A27 020E0B 11170F 11080D 020926 06160C 110A27 020E0B 11170F
111E2E 021F2F 06424A 111828 061929 111A2A 021B2B

// File: test/tb_ecc_pm.sv
/*
 * Testbench for the point-multiplication control subsystem
 * Replays the test file over APB and checks the issued instruction stream
 */
`timescale 1ns/100ps
`include "ecc_pm_macros.svh"

module tb_ecc_pm;

    logic               clk = 1'b0;
    logic               reset_n;
    logic [3:0]         paddr_i;
    logic               psel_i;
    logic               penable_i;
    logic               pwrite_i;
    logic [31:0]        pwdata_i;
    logic [31:0]        prdata_o;
    logic               pready_o;
    logic               pslverr_o;
    logic               busy_o;
    ecc_pm_pkg::instr_t instr_o;

    logic [31:0]        tokens[$];  // Flattened test file
    ecc_pm_pkg::instr_t seen[$];    // Non-zero words from instr_o
    int                 cycles = 0;
    int                 cycle_limit = 0;

    ecc_pm_top uut (
        .clk       (clk),
        .reset_n   (reset_n),
        .paddr_i   (paddr_i),
        .psel_i    (psel_i),
        .penable_i (penable_i),
        .pwrite_i  (pwrite_i),
        .pwdata_i  (pwdata_i),
        .prdata_o  (prdata_o),
        .pready_o  (pready_o),
        .pslverr_o (pslverr_o),
        .busy_o    (busy_o),
        .instr_o   (instr_o)
    );

    always #10 clk = ~clk;  // 20 ns period

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycle_limit != 0 && cycles >= cycle_limit) begin
            $display("Timeout after %0d cycles, the DUT never finished", cycles);
            $display("CHECKS FAILED");
            $fatal(1, "Simulation timed out");
        end
    end

    always @(negedge clk) begin
        if (reset_n && instr_o != '0) begin
            seen.push_back(instr_o);
        end
    end

    // --------------------------------------------------
    // Checking and APB helpers
    // --------------------------------------------------
    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("CHECK FAILED %s: got %h, expected %h", name, got, expected);
            $display("CHECKS FAILED");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    // Setup then access phase without wait states
    task automatic apb_transfer(input logic write, input logic [3:0] addr,
                                input logic [31:0] wdata, output logic [31:0] rdata,
                                output logic err);
        @(posedge clk);
        #2;
        psel_i    = 1'b1;
        penable_i = 1'b0;
        pwrite_i  = write;
        paddr_i   = addr;
        pwdata_i  = wdata;
        @(posedge clk);
        #2;
        penable_i = 1'b1;
        @(negedge clk);
        check_value("pready_o", 32'(pready_o), 32'h1);
        rdata = prdata_o;
        err   = pslverr_o;
        @(posedge clk);
        #2;
        psel_i    = 1'b0;
        penable_i = 1'b0;
        pwrite_i  = 1'b0;
    endtask

    task automatic apb_write(input logic [3:0] addr, input logic [31:0] wdata,
                             input logic exp_err);
        logic [31:0] rdata;
        logic        err;
        apb_transfer(1'b1, addr, wdata, rdata, err);
        check_value("pslverr_o", 32'(err), 32'(exp_err));
    endtask

    task automatic read_status(output logic [31:0] rdata);
        logic err;
        apb_transfer(1'b0, `PM_REG_STATUS, 32'h0, rdata, err);
        check_value("pslverr_o", 32'(err), 32'h0);
    endtask

    // --------------------------------------------------
    // Test file loading
    // --------------------------------------------------
    task automatic load_tests();
        int          fd;
        int          n;
        logic [31:0] value;
        string       skipped;
        fd = $fopen("test/ecc_pm_tests.txt", "r");
        if (fd == 0) begin
            $display("Cannot open test/ecc_pm_tests.txt");
            $display("CHECKS FAILED");
            $fatal(1, "Missing test file");
        end
        while (!$feof(fd)) begin
            n = $fscanf(fd, "%h", value);
            if (n == 1) begin
                tokens.push_back(value);
            end else begin
                n = $fgets(skipped, fd);  // Comment line
            end
        end
        $fclose(fd);
    endtask

    function automatic int count_tests();
        int pos;
        int num;
        pos = 0;
        num = 0;
        while (pos + 3 < tokens.size()) begin
            num = num + 1;
            pos = pos + 4 + int'(tokens[pos + 3]);
        end
        return num;
    endfunction

    initial begin
        logic [31:0] cmd;
        logic [31:0] scalar;
        logic [31:0] remaining;
        logic [31:0] count;
        logic [31:0] rdata;
        int          num_tests;
        int          pos;
        reset_n   = 1'b0;
        paddr_i   = 4'h0;
        psel_i    = 1'b0;
        penable_i = 1'b0;
        pwrite_i  = 1'b0;
        pwdata_i  = 32'h0;
        load_tests();
        num_tests = count_tests();
        if (num_tests == 0) begin
            $display("The test file holds no tests");
            $display("CHECKS FAILED");
            $fatal(1, "Empty test file");
        end
        cycle_limit = num_tests * (`PM_LADDER_BITS + 10) * 45 * 4;
        repeat (4) @(posedge clk);
        #2;
        reset_n = 1'b1;

        @(negedge clk);
        check_value("instr_o", 32'(instr_o), 32'h0);
        check_value("busy_o", 32'(busy_o), 32'h0);
        read_status(rdata);
        check_value("status busy", 32'(rdata[0]), 32'h0);
        apb_write(`PM_REG_CMD, 32'h7, 1'b1);  // Undefined code
        repeat (2 * (`PM_MUL_DELAY + 2)) @(negedge clk);  // Past any routine's first word
        check_value("busy_o", 32'(busy_o), 32'h0);
        check_value("instr_o word count", 32'(seen.size()), 32'h0);

        pos = 0;
        while (pos + 3 < tokens.size()) begin
            cmd       = tokens[pos];
            scalar    = tokens[pos + 1];
            remaining = tokens[pos + 2];
            count     = tokens[pos + 3];
            pos       = pos + 4;
            $display("Command %0d with scalar %h", cmd, scalar);
            apb_write(`PM_REG_SCALAR, scalar, 1'b0);
            seen.delete();
            apb_write(`PM_REG_CMD, cmd, 1'b0);
            while (!busy_o) @(negedge clk);
            apb_write(`PM_REG_CMD, cmd, 1'b1);  // Rejected while running
            while (busy_o) @(negedge clk);
            @(posedge clk);
            #2;
            for (int i = 0; i < int'(count) && i < seen.size(); i++) begin
                check_value("instr_o", 32'(seen[i]), tokens[pos + i]);
            end
            check_value("instr_o word count", 32'(seen.size()), count);
            pos = pos + int'(count);
            read_status(rdata);
            check_value("status", rdata, remaining << 8);
        end

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule
